/* dv/sa_ref_model.svh */
`ifndef SA_REF_MODEL_SVH
`define SA_REF_MODEL_SVH

// one pixel pair times one weight, placed at the lane offsets of each mode
function automatic longint pe_term(input sa_mode_e m, input sa_pix_t pix, input sa_wgt_t wgt);
    longint lo;
    longint hi;
    longint w;
    longint s_hi;
    longint s_lo;
    lo = {56'd0, pix.lo};
    hi = {56'd0, pix.hi};
    w = longint'($signed(wgt));
    s_hi = wgt[1] ? -64'sd1 : 64'sd1;
    s_lo = wgt[0] ? -64'sd1 : 64'sd1;
    if (m == mode_88) begin
        return w * (lo + (hi << 16));
    end
    // +/-1 at bit 16 and at bit 0, pixels at bits 8 and 0
    return s_hi * ((hi << 24) + (lo << 16)) + s_lo * ((hi << 8) + lo);
endfunction

// pixel reaches row r after r cycles, weight reaches column c after c cycles
function automatic sa_acc_t expected_acc(input sa_mode_e m, input int idx, input int r,
                                         input int c);
    sa_acc_t acc;
    acc.raw = '0;
    if (r < idx || c < idx) begin
        return acc;
    end
    for (int t = 0; t < hist_len; t++) begin
        if (t >= r && t >= c) begin
            acc.raw = acc.raw + pe_term(m, pix_hist[t-r][c], wgt_hist[t-c][r]);
        end
    end
    return acc;
endfunction

function automatic sa_row_out_t expected_row(input sa_mode_e m, input int idx, input int r);
    sa_row_out_t row;
    logic [`SA_ACC_W-1:0] a;
    row = '0;
    for (int c = 0; c < `SA_COLS; c++) begin
        a = expected_acc(m, idx, r, c).raw;
        if (m == mode_88) begin
            row.m88.lane[c][0] = a[23:0];
            row.m88.lane[c][1] = a[47:24];
        end else begin
            row.m18.lower[c][0] = a[15:0];
            row.m18.lower[c][1] = a[31:16];
            row.m18.upper[c][0] = a[47:32];
            row.m18.upper[c][1] = a[63:48];
        end
    end
    return row;
endfunction

function automatic sa_mult_p_t expected_mult(input sa_mult_a_t s, input sa_mult_b_t e);
    longint p;
    p = longint'(s) * longint'(e);
    return p[`SA_MULT_P_W-1:0];
endfunction

`endif

/* dv/tb_sa_array.sv */
`timescale 1ns/1ps

`include "sa_consts.svh"

module tb_sa_array
    import sa_ctrl_pkg::*;
    import sa_data_pkg::*;
();

    localparam int max_cyc   = 64;
    localparam int drain_cyc = `SA_ROWS + `SA_COLS;

    logic                       clk = 1'b0;
    logic                       channel_out_reset;
    logic                       en;
    sa_mode_e                   mode;
    logic                       mult_array_mode;
    sa_wgt_t    [`SA_ROWS-1:0]  row_in;
    sa_pix_t    [`SA_COLS-1:0]  column_in;
    sa_row_idx_t                out_sa_row_idx;
    logic                       channel_out_en;
    sa_mult_b_t [`SA_COLS-1:0]  sa_E_ins;
    sa_mult_a_t [`SA_COLS-1:0]  sa_sum_in;
    sa_row_out_t                out;
    sa_mult_p_t [`SA_COLS-1:0]  row0_out;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    // operands applied at the array edge per enabled cycle
    sa_pix_t pix_hist [max_cyc][`SA_COLS];
    sa_wgt_t wgt_hist [max_cyc][`SA_ROWS];
    int      hist_len;

`include "sa_ref_model.svh"

    always #50 clk = ~clk;

    sa_array u_sa_array (.*);

    ////////////////////////////////////////////////////////////////////////////
    // random source and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_row(input string name, input sa_row_out_t got, input sa_row_out_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mult(input string name, input sa_mult_p_t got, input sa_mult_p_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_zero_out(input string note);
        checks++;
        if (out !== '0) begin
            errors++;
            $display("ERROR at %0t: out (%s) got %h expected 0", $time, note, out);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic do_reset();
        @(posedge clk);
        channel_out_reset <= 1'b1;
        en                <= 1'b0;
        channel_out_en    <= 1'b0;
        mult_array_mode   <= 1'b0;
        repeat (3) @(posedge clk);
        channel_out_reset <= 1'b0;
    endtask

    // random operands for n cycles, then zeros until the skew drains
    task automatic accumulate(input sa_mode_e m, input int idx, input int n);
        logic [31:0] bits;
        do_reset();
        mode           <= m;
        out_sa_row_idx <= sa_row_idx_t'(idx);
        en             <= 1'b1;
        hist_len = n + drain_cyc;
        for (int t = 0; t < hist_len; t++) begin
            for (int c = 0; c < `SA_COLS; c++) begin
                bits = (t < n) ? rand_bits(16) : '0;
                pix_hist[t][c] = bits[15:0];
                column_in[c] <= bits[15:0];
            end
            for (int r = 0; r < `SA_ROWS; r++) begin
                bits = (t >= n) ? '0 : ((m == mode_88) ? rand_bits(8) : rand_bits(2));
                wgt_hist[t][r] = bits[7:0];
                row_in[r] <= bits[7:0];
            end
            @(posedge clk);
        end
        en <= 1'b0;
    endtask

    // strobe held one cycle per row and each row checked mid-cycle
    task automatic read_rows(input sa_mode_e m, input int idx, input int count);
        int r;
        channel_out_en <= 1'b1;
        for (int k = 0; k < count; k++) begin
            r = k % `SA_ROWS;
            @(negedge clk);
            check_row($sformatf("out row %0d", r), out, expected_row(m, idx, r));
            @(posedge clk);
        end
        channel_out_en <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    // runs with accumulators and row0_out still loaded
    task automatic test_reset_state();
        do_reset();
        hist_len = 0;
        @(negedge clk);
        check_zero_out("after reset");
        for (int c = 0; c < `SA_COLS; c++) begin
            check_mult($sformatf("row0_out[%0d]", c), row0_out[c], '0);
        end
        @(posedge clk);
        read_rows(mode_88, 0, `SA_ROWS);
    endtask

    task automatic test_accumulate(input sa_mode_e m, input int idx, input int n);
        accumulate(m, idx, n);
        @(negedge clk);
        check_zero_out("strobe low");
        @(posedge clk);
        read_rows(m, idx, `SA_ROWS);
    endtask

    // two strobes past the last row leave the counter at 2 before reset
    task automatic test_row_wrap();
        accumulate(mode_88, 0, 8);
        read_rows(mode_88, 0, `SA_ROWS + 2);
        accumulate(mode_88, 0, 8);
        read_rows(mode_88, 0, `SA_ROWS);
    endtask

    task automatic test_mult_mode(input int n);
        logic [31:0] s;
        logic [31:0] e;
        sa_mult_p_t  exp [`SA_COLS];
        sa_mult_p_t  nxt [`SA_COLS];
        @(posedge clk);
        mult_array_mode <= 1'b1;
        for (int c = 0; c < `SA_COLS; c++) begin
            exp[c] = '0;
            nxt[c] = '0;
        end
        // row0_out shows the product of the operands applied before the last edge
        for (int k = 0; k <= n; k++) begin
            if (k < n) begin
                for (int c = 0; c < `SA_COLS; c++) begin
                    s = rand_bits(24);
                    e = rand_bits(16);
                    nxt[c] = expected_mult(s[23:0], e[15:0]);
                    sa_sum_in[c] <= s[23:0];
                    sa_E_ins[c]  <= e[15:0];
                end
            end
            @(negedge clk);
            for (int c = 0; c < `SA_COLS; c++) begin
                check_mult($sformatf("row0_out[%0d]", c), row0_out[c], exp[c]);
                exp[c] = nxt[c];
            end
            @(posedge clk);
        end
        mult_array_mode <= 1'b0;
    endtask

    initial begin
        lfsr_state = 32'hdbff56e5;
        errors     = 0;
        checks     = 0;
        hist_len   = 0;
        channel_out_reset <= 1'b1;
        en                <= 1'b0;
        mode              <= mode_88;
        mult_array_mode   <= 1'b0;
        row_in            <= '0;
        column_in         <= '0;
        out_sa_row_idx    <= '0;
        channel_out_en    <= 1'b0;
        sa_E_ins          <= '0;
        sa_sum_in         <= '0;

        do_reset();
        test_accumulate(mode_88, 0, 12);
        test_accumulate(mode_18, 0, 12);
        test_row_wrap();
        test_accumulate(mode_88, 2, 12);
        test_mult_mode(16);
        test_reset_state();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sa_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sa_array \
    -f sources.f -o tb_sa_array > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $build_log"
    exit 1
fi

./obj_dir/tb_sa_array > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $sim_log"
    exit 1
fi

# the log decides the result
if grep -qx "Test passed" "$sim_log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $sim_log"
exit 1

/* sources.f */
+incdir+src
+incdir+dv
src/sa_ctrl_pkg.sv
src/sa_data_pkg.sv
src/sa_operand_prep.sv
src/sa_pe.sv
src/sa_readout_ctrl.sv
src/sa_out_format.sv
src/sa_array.sv
dv/tb_sa_array.sv

/* src/sa_array.sv */
`timescale 1ns/1ps

`include "sa_consts.svh"

module sa_array
    import sa_ctrl_pkg::*;
    import sa_data_pkg::*;
(
    input  logic                          clk,
    input  logic                          channel_out_reset,
    input  logic                          en,
    input  sa_mode_e                      mode,
    input  logic                          mult_array_mode,
    input  sa_wgt_t     [`SA_ROWS-1:0]    row_in,
    input  sa_pix_t     [`SA_COLS-1:0]    column_in,
    input  sa_row_idx_t                   out_sa_row_idx,
    input  logic                          channel_out_en,
    input  sa_mult_b_t  [`SA_COLS-1:0]    sa_E_ins,
    input  sa_mult_a_t  [`SA_COLS-1:0]    sa_sum_in,
    output sa_row_out_t                   out,
    output sa_mult_p_t  [`SA_COLS-1:0]    row0_out
);

    sa_ctrl_t ctrl;

    // pixel links run top to bottom, entry 0 is the prep output
    sa_op_a_t [`SA_ROWS:0][`SA_COLS-1:0]     a_link;
    // weight links indexed by column first, entry 0 is the prep output
    sa_op_b_t [`SA_COLS:0][`SA_ROWS-1:0]     b_link;

    sa_acc_t    [`SA_ROWS-1:0][`SA_COLS-1:0] acc_grid;
    sa_mult_p_t [`SA_ROWS-1:0][`SA_COLS-1:0] mult_p_grid;

    sa_row_sel_t                row_sel;
    logic [`SA_ROWS-1:0]        row_en_mask;
    logic [`SA_COLS-1:0]        col_en_mask;

    assign ctrl.mode            = mode;
    assign ctrl.mult_array_mode = mult_array_mode;
    assign ctrl.en              = en;

    sa_operand_prep u_prep (
        .ctrl      (ctrl),
        .row_in    (row_in),
        .column_in (column_in),
        .op_a      (a_link[0]),
        .op_b      (b_link[0])
    );

    sa_readout_ctrl u_readout_ctrl (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .ctrl              (ctrl),
        .channel_out_en    (channel_out_en),
        .out_sa_row_idx    (out_sa_row_idx),
        .row_sel           (row_sel),
        .row_en_mask       (row_en_mask),
        .col_en_mask       (col_en_mask)
    );

    ////////////////////////////////////////////////////////////////////////////
    // PE grid, row 0 carries the external multiplier
    ////////////////////////////////////////////////////////////////////////////

    for (genvar r = 0; r < `SA_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `SA_COLS; c++) begin : g_col
            sa_pe #(
                .has_ext_mult (r == 0)
            ) u_pe (
                .clk               (clk),
                .channel_out_reset (channel_out_reset),
                .ctrl              (ctrl),
                .pe_en             (row_en_mask[r] & col_en_mask[c]),
                .a_in              (a_link[r][c]),
                .b_in              (b_link[c][r]),
                .ext_sum           ((r == 0) ? sa_sum_in[c] : '0),
                .ext_e             ((r == 0) ? sa_E_ins[c] : '0),
                .a_out             (a_link[r+1][c]),
                .b_out             (b_link[c+1][r]),
                .acc               (acc_grid[r][c]),
                .mult_p            (mult_p_grid[r][c])
            );
        end
    end

    assign row0_out = mult_p_grid[0];

    sa_out_format u_out_format (
        .ctrl           (ctrl),
        .channel_out_en (channel_out_en),
        .row_sel        (row_sel),
        .acc_grid       (acc_grid),
        .out            (out)
    );

endmodule

/* src/sa_consts.svh */
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

// array geometry
`define SA_ROWS       4
`define SA_COLS       4

// raw input widths
`define SA_PIX_W      8
`define SA_WGT_W      8

// packed multiplier operands and accumulator
`define SA_A_W        24
`define SA_B_W        18
`define SA_ACC_W      64
`define SA_LANE88_W   24
`define SA_LANE18_W   16

// row-0 external multiplier
`define SA_MULT_A_W   24
`define SA_MULT_B_W   16
`define SA_MULT_P_W   40

// readout row counter and row/column start index
`define SA_ROW_CNT_W  2
`define SA_IDX_W      3

`endif

/* src/sa_ctrl_pkg.sv */
package sa_ctrl_pkg;

`include "sa_consts.svh"

    // precision modes
    //   mode_88: signed 8-bit weight times two unsigned 8-bit pixels
    //   mode_18: 2-bit weight field times two unsigned 8-bit pixels
    typedef enum logic {
        mode_88 = 1'b0,
        mode_18 = 1'b1
    } sa_mode_e;

    // levels shared by prep, PEs, controller and formatter
    typedef struct packed {
        sa_mode_e mode;
        logic     mult_array_mode;
        logic     en;
    } sa_ctrl_t;

    // readout row pointer
    typedef logic [`SA_ROW_CNT_W-1:0] sa_row_sel_t;

    // lowest enabled row and column
    typedef logic [`SA_IDX_W-1:0] sa_row_idx_t;

endpackage

/* src/sa_data_pkg.sv */
package sa_data_pkg;

`include "sa_consts.svh"

    ////////////////////////////////////////////////////////////////////////////
    // raw edge inputs
    ////////////////////////////////////////////////////////////////////////////

    // two unsigned pixels per column
    typedef struct packed {
        logic [`SA_PIX_W-1:0] hi;
        logic [`SA_PIX_W-1:0] lo;
    } sa_pix_t;

    typedef logic [`SA_WGT_W-1:0] sa_wgt_t;

    // lane-encoded multiplier operands
    typedef logic [`SA_A_W-1:0] sa_op_a_t;
    typedef logic signed [`SA_B_W-1:0] sa_op_b_t;

    ////////////////////////////////////////////////////////////////////////////
    // accumulator views
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`SA_ACC_W-2*`SA_LANE88_W-1:0] pad;
        logic [`SA_LANE88_W-1:0]             hi;
        logic [`SA_LANE88_W-1:0]             lo;
    } sa_lanes88_t;

    typedef struct packed {
        logic [`SA_ACC_W/`SA_LANE18_W-1:0][`SA_LANE18_W-1:0] lane;
    } sa_lanes18_t;

    typedef union packed {
        sa_lanes88_t          m88;
        sa_lanes18_t          m18;
        logic [`SA_ACC_W-1:0] raw;
    } sa_acc_t;

    ////////////////////////////////////////////////////////////////////////////
    // formatted readout row
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`SA_COLS*(`SA_ACC_W-2*`SA_LANE88_W)-1:0]  pad;
        logic [`SA_COLS-1:0][1:0][`SA_LANE88_W-1:0]      lane;
    } sa_row88_t;

    // low lane pairs in the lower half, high lane pairs in the upper half
    typedef struct packed {
        logic [`SA_COLS-1:0][1:0][`SA_LANE18_W-1:0] upper;
        logic [`SA_COLS-1:0][1:0][`SA_LANE18_W-1:0] lower;
    } sa_row18_t;

    typedef union packed {
        sa_row88_t m88;
        sa_row18_t m18;
    } sa_row_out_t;

    // row-0 external multiplier operands and product
    typedef logic signed [`SA_MULT_A_W-1:0] sa_mult_a_t;
    typedef logic signed [`SA_MULT_B_W-1:0] sa_mult_b_t;
    typedef logic signed [`SA_MULT_P_W-1:0] sa_mult_p_t;

endpackage

/* src/sa_operand_prep.sv */
`timescale 1ns/1ps

`include "sa_consts.svh"

module sa_operand_prep
    import sa_ctrl_pkg::*;
    import sa_data_pkg::*;
(
    input  sa_ctrl_t                     ctrl,
    input  sa_wgt_t  [`SA_ROWS-1:0]      row_in,
    input  sa_pix_t  [`SA_COLS-1:0]      column_in,
    output sa_op_a_t [`SA_COLS-1:0]      op_a,
    output sa_op_b_t [`SA_ROWS-1:0]      op_b
);

    ////////////////////////////////////////////////////////////////////////////
    // pixel operand, one per column
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < `SA_COLS; c++) begin
            if (ctrl.mode == mode_88) begin
                // high pixel at bit 16, gap keeps the low lane clear
                op_a[c] = {column_in[c].hi,
                           {(`SA_A_W-2*`SA_PIX_W){1'b0}},
                           column_in[c].lo};
            end else begin
                // high pixel at bit 8
                op_a[c] = {{(`SA_A_W-2*`SA_PIX_W){1'b0}},
                           column_in[c].hi,
                           column_in[c].lo};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // weight operand, one per row
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [`SA_B_W-1:0] b_hi;
        logic [`SA_B_W-1:0] b_lo;

        for (int r = 0; r < `SA_ROWS; r++) begin
            // weight bit 1 picks +1 or -1 at bit 16
            b_hi = {row_in[r][1], 1'b1, {(`SA_B_W-2){1'b0}}};
            // weight bit 0 picks +1 or -1 at bit 0
            b_lo = {{(`SA_B_W-1){row_in[r][0]}}, 1'b1};

            if (ctrl.mode == mode_88) begin
                op_b[r] = {{(`SA_B_W-`SA_WGT_W){row_in[r][`SA_WGT_W-1]}}, row_in[r]};
            end else begin
                op_b[r] = b_hi + b_lo;
            end
        end
    end

endmodule

/* src/sa_out_format.sv */
`timescale 1ns/1ps

`include "sa_consts.svh"

module sa_out_format
    import sa_ctrl_pkg::*;
    import sa_data_pkg::*;
(
    input  sa_ctrl_t                                 ctrl,
    input  logic                                     channel_out_en,
    input  sa_row_sel_t                              row_sel,
    input  sa_acc_t [`SA_ROWS-1:0][`SA_COLS-1:0]     acc_grid,
    output sa_row_out_t                              out
);

    sa_acc_t [`SA_COLS-1:0] row_acc;

    // addressed accumulator row
    assign row_acc = acc_grid[row_sel];

    ////////////////////////////////////////////////////////////////////////////
    // lane rearrangement
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        out = '0;
        if (channel_out_en) begin
            if (ctrl.mode == mode_88) begin
                // two 24-bit lanes per column, top of the word left at zero
                out.m88.pad = '0;
                for (int c = 0; c < `SA_COLS; c++) begin
                    out.m88.lane[c][0] = row_acc[c].m88.lo;
                    out.m88.lane[c][1] = row_acc[c].m88.hi;
                end
            end else begin
                // lanes 0/1 of every column first, then lanes 2/3
                for (int c = 0; c < `SA_COLS; c++) begin
                    out.m18.lower[c][0] = row_acc[c].m18.lane[0];
                    out.m18.lower[c][1] = row_acc[c].m18.lane[1];
                    out.m18.upper[c][0] = row_acc[c].m18.lane[2];
                    out.m18.upper[c][1] = row_acc[c].m18.lane[3];
                end
            end
        end
    end

endmodule

/* src/sa_pe.sv */
`timescale 1ns/1ps

`include "sa_consts.svh"

module sa_pe
    import sa_ctrl_pkg::*;
    import sa_data_pkg::*;
#(
    parameter bit has_ext_mult = 1'b0
) (
    input  logic       clk,
    input  logic       channel_out_reset,
    input  sa_ctrl_t   ctrl,
    input  logic       pe_en,
    input  sa_op_a_t   a_in,
    input  sa_op_b_t   b_in,
    input  sa_mult_a_t ext_sum,
    input  sa_mult_b_t ext_e,
    output sa_op_a_t   a_out,
    output sa_op_b_t   b_out,
    output sa_acc_t    acc,
    output sa_mult_p_t mult_p
);

    // pixel operand is unsigned, so one extra bit before the signed multiply
    localparam int prod_w = `SA_A_W + 1 + `SA_B_W;

    logic signed [prod_w-1:0]    prod;
    logic [`SA_ACC_W-1:0]        prod_ext;
    logic                        accum_en;

    ////////////////////////////////////////////////////////////////////////////
    // packed multiply-accumulate
    ////////////////////////////////////////////////////////////////////////////

    assign prod     = $signed({1'b0, a_in}) * b_in;
    assign prod_ext = {{(`SA_ACC_W-prod_w){prod[prod_w-1]}}, prod};

    // row 0 stops accumulating while it serves as the external multiplier
    assign accum_en = pe_en && !(has_ext_mult && ctrl.mult_array_mode);

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            a_out   <= '0;
            b_out   <= '0;
            acc.raw <= '0;
        end else begin
            // one hop per cycle, down for pixels and right for weights
            a_out <= a_in;
            b_out <= b_in;
            if (accum_en) begin
                acc.raw <= acc.raw + prod_ext;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // row-0 external multiplier
    ////////////////////////////////////////////////////////////////////////////

    generate
        if (has_ext_mult) begin : g_ext_mult
            sa_mult_p_t ext_prod;

            // E coefficient sign-extends through the signed product
            assign ext_prod = ext_sum * ext_e;

            always_ff @(posedge clk) begin
                if (channel_out_reset) begin
                    mult_p <= '0;
                end else if (ctrl.mult_array_mode) begin
                    mult_p <= ext_prod;
                end
            end
        end else begin : g_no_ext_mult
            assign mult_p = '0;
        end
    endgenerate

endmodule

/* src/sa_readout_ctrl.sv */
`timescale 1ns/1ps

`include "sa_consts.svh"

module sa_readout_ctrl
    import sa_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                channel_out_reset,
    input  sa_ctrl_t            ctrl,
    input  logic                channel_out_en,
    input  sa_row_idx_t         out_sa_row_idx,
    output sa_row_sel_t         row_sel,
    output logic [`SA_ROWS-1:0] row_en_mask,
    output logic [`SA_COLS-1:0] col_en_mask
);

    logic last_row;

    ////////////////////////////////////////////////////////////////////////////
    // readout row counter
    ////////////////////////////////////////////////////////////////////////////

    assign last_row = (row_sel == sa_row_sel_t'(`SA_ROWS - 1));

    // advances once per strobe cycle, wraps after the last row
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_sel <= '0;
        end else if (channel_out_en) begin
            if (last_row) begin
                row_sel <= '0;
            end else begin
                row_sel <= row_sel + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulate enables
    ////////////////////////////////////////////////////////////////////////////

    // rows and columns below the start index stay idle
    always_comb begin
        for (int r = 0; r < `SA_ROWS; r++) begin
            row_en_mask[r] = ctrl.en && (r >= int'(out_sa_row_idx));
        end
        for (int c = 0; c < `SA_COLS; c++) begin
            col_en_mask[c] = ctrl.en && (c >= int'(out_sa_row_idx));
        end
    end

endmodule
